//--- exec_stage.f
source/alu_pkg.sv
source/mul_booth2.sv
source/div_radix2.sv
source/alu.sv
source/exec_stage.sv
bench/clock_gen.sv
bench/exec_stage_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = exec_stage_tb
FILELIST  = exec_stage.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SOURCES = $(wildcard source/*.sv bench/*.sv)
SIM     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/exec_stage_tb.sv
`timescale 1ns/1ps

module exec_stage_tb;
    import alu_pkg::*;

    localparam int clk_period = 100;
    localparam int rst_cycles = 10;

    typedef struct packed {
        alu_op_e    op;
        word_t      a;
        word_t      b;
        shamt_t     sa;
        logic       flush;      // kill the divide midway
        hilo_word_u exp_out;
        logic       exp_ovf;
        hilo_pair_t exp_hilo;
    } entry_t;

    logic       clk;
    logic       rst;
    logic       flush;
    word_t      src_a;
    word_t      src_b;
    alu_op_e    alu_control;
    shamt_t     sa;
    hilo_word_u alu_out;
    logic       overflow;
    logic       div_stall;
    hilo_pair_t hilo;

    entry_t     table_q[$];
    hilo_pair_t model_hilo;
    int         seed;
    int         word_errs;
    int         pair_errs;
    int         bit_errs;
    bit         table_ready;

    clock_gen i_clk (.clk(clk));

    exec_stage i_dut (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_control (alu_control),
        .sa          (sa),
        .alu_out     (alu_out),
        .overflow    (overflow),
        .div_stall   (div_stall),
        .hilo        (hilo)
    );

    function automatic hilo_word_u model_out(alu_op_e op, word_t a, word_t b, shamt_t s,
                                             hilo_pair_t hl);
        hilo_word_u  w;
        logic [63:0] ea;
        logic [63:0] eb;
        word_t       am;
        word_t       bm;
        word_t       q;
        word_t       r;
        w = '0;
        case (op)
            alu_and:    w.hl.lo = a & b;
            alu_or:     w.hl.lo = a | b;
            alu_nor:    w.hl.lo = ~(a | b);
            alu_xor:    w.hl.lo = a ^ b;
            alu_add, alu_addu: w.hl.lo = a + b;
            alu_sub, alu_subu: w.hl.lo = a - b;
            alu_slt:    w.hl.lo = {31'b0, $signed(a) < $signed(b)};
            alu_sltu:   w.hl.lo = {31'b0, a < b};
            alu_sll:    w.hl.lo = b << a[4:0];
            alu_srl:    w.hl.lo = b >> a[4:0];
            alu_sra:    w.hl.lo = $signed(b) >>> a[4:0];
            alu_sll_sa: w.hl.lo = b << s;
            alu_srl_sa: w.hl.lo = b >> s;
            alu_sra_sa: w.hl.lo = $signed(b) >>> s;
            alu_lui:    w.hl.lo = {b[15:0], 16'h0000};
            alu_pass:   w.hl.lo = a;
            alu_mthi:   w.hl = {a, hl.lo};
            alu_mtlo:   w.hl = {hl.hi, a};
            alu_mult: begin
                ea = {{32{a[31]}}, a};
                eb = {{32{b[31]}}, b};
                w.hl = ea * eb;     // low 64 bits of the sign-extended product
            end
            alu_multu:  w.hl = {32'h0, a} * {32'h0, b};
            alu_div: begin
                am = a[31] ? -a : a;
                bm = b[31] ? -b : b;
                q = am / bm;
                r = am % bm;
                w.qr.quot = (a[31] ^ b[31]) ? -q : q;
                w.qr.rem  = a[31] ? -r : r;
            end
            alu_divu: begin
                if (b == '0) begin
                    w.qr.quot = '1;
                    w.qr.rem  = a;
                end else begin
                    w.qr.quot = a / b;
                    w.qr.rem  = a % b;
                end
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic logic model_ovf(alu_op_e op, word_t a, word_t b);
        word_t s;
        case (op)
            alu_add: begin
                s = a + b;
                return (a[31] == b[31]) && (s[31] != a[31]);
            end
            alu_sub: begin
                s = a - b;
                return (a[31] != b[31]) && (s[31] != a[31]);
            end
            default: return 1'b0;
        endcase
    endfunction

    function automatic void add_entry(alu_op_e op, word_t a, word_t b, shamt_t s, logic kill);
        entry_t e;
        e.op      = op;
        e.a       = a;
        e.b       = b;
        e.sa      = s;
        e.flush   = kill;
        e.exp_out = model_out(op, a, b, s, model_hilo);
        e.exp_ovf = model_ovf(op, a, b);
        if (!kill && op inside {alu_mult, alu_multu, alu_div, alu_divu, alu_mthi, alu_mtlo}) begin
            model_hilo = e.exp_out.hl;
        end
        e.exp_hilo = model_hilo;
        table_q.push_back(e);
    endfunction

    task automatic fill_table;
        word_t   r;
        word_t   ra;
        word_t   rb;
        alu_op_e op;
        add_entry(alu_and, 32'hf0f0a5a5, 32'h0ff05a5a, 5'd0, 1'b0);
        add_entry(alu_or,  32'hf0f0a5a5, 32'h0ff05a5a, 5'd0, 1'b0);
        add_entry(alu_nor, 32'hf0f0a5a5, 32'h0ff05a5a, 5'd0, 1'b0);
        add_entry(alu_xor, 32'hf0f0a5a5, 32'h0ff05a5a, 5'd0, 1'b0);
        add_entry(alu_add,  32'h7fffffff, 32'h00000001, 5'd0, 1'b0);
        add_entry(alu_add,  32'h80000000, 32'hffffffff, 5'd0, 1'b0);
        add_entry(alu_add,  32'h00000005, 32'hfffffffd, 5'd0, 1'b0);
        add_entry(alu_addu, 32'h7fffffff, 32'h00000001, 5'd0, 1'b0);
        add_entry(alu_sub,  32'h80000000, 32'h00000001, 5'd0, 1'b0);
        add_entry(alu_sub,  32'h7fffffff, 32'hffffffff, 5'd0, 1'b0);
        add_entry(alu_subu, 32'h80000000, 32'h00000001, 5'd0, 1'b0);
        add_entry(alu_slt,  32'hffffffff, 32'h00000001, 5'd0, 1'b0);
        add_entry(alu_sltu, 32'hffffffff, 32'h00000001, 5'd0, 1'b0);
        add_entry(alu_sll,  32'h00000021, 32'h80000001, 5'd0, 1'b0);   // only a[4:0] counts
        add_entry(alu_srl,  32'h0000001f, 32'h80000000, 5'd0, 1'b0);
        add_entry(alu_sra,  32'h0000001f, 32'h80000000, 5'd0, 1'b0);
        add_entry(alu_sll_sa, 32'h0, 32'h8f00000f, 5'd4,  1'b0);
        add_entry(alu_srl_sa, 32'h0, 32'h8f00000f, 5'd31, 1'b0);
        add_entry(alu_sra_sa, 32'h0, 32'h8f00000f, 5'd7,  1'b0);
        add_entry(alu_lui,  32'h0, 32'h1234abcd, 5'd0, 1'b0);
        add_entry(alu_pass, 32'hdeadbeef, 32'h0, 5'd0, 1'b0);
        add_entry(alu_mthi, 32'h11112222, 32'h0, 5'd0, 1'b0);
        add_entry(alu_mtlo, 32'h33334444, 32'h0, 5'd0, 1'b0);
        add_entry(alu_mthi, 32'h55556666, 32'h0, 5'd0, 1'b0);
        add_entry(alu_mult,  32'h80000000, 32'h80000000, 5'd0, 1'b0);
        add_entry(alu_mult,  32'hffffffff, 32'hffffffff, 5'd0, 1'b0);
        add_entry(alu_mult,  32'h7fffffff, 32'h80000000, 5'd0, 1'b0);
        add_entry(alu_multu, 32'hffffffff, 32'hffffffff, 5'd0, 1'b0);
        add_entry(alu_div,  32'hfffffff9, 32'h00000002, 5'd0, 1'b0);   // -7 / 2
        add_entry(alu_div,  32'h00000007, 32'hfffffffe, 5'd0, 1'b0);
        add_entry(alu_div,  32'hfffffff9, 32'hfffffffe, 5'd0, 1'b0);
        add_entry(alu_div,  32'h80000000, 32'hffffffff, 5'd0, 1'b0);
        add_entry(alu_divu, 32'hffffffff, 32'h00000003, 5'd0, 1'b0);
        add_entry(alu_divu, 32'h12345678, 32'h00000000, 5'd0, 1'b0);   // divide by zero
        add_entry(alu_divu, 32'h00abcdef, 32'h00000013, 5'd0, 1'b1);
        add_entry(alu_mtlo, 32'h77778888, 32'h0, 5'd0, 1'b0);
        add_entry(alu_op_e'(5'd24), 32'hffffffff, 32'hffffffff, 5'd3, 1'b0);
        for (int i = 0; i < 8; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            case (i % 4)
                0: op = alu_mult;
                1: op = alu_multu;
                2: op = alu_div;
                default: op = alu_divu;
            endcase
            if (rb == '0) begin
                rb = 32'd1;
            end
            add_entry(op, ra, rb, 5'd0, 1'b0);
        end
        for (int i = 0; i < 40; i++) begin
            r  = $random(seed);
            ra = $random(seed);
            rb = $random(seed);
            op = alu_op_e'(5'(r % 24));
            if (rb == '0) begin
                rb = 32'd1;     // signed divide by zero is undefined
            end
            add_entry(op, ra, rb, shamt_t'(r[12:8]), 1'b0);
        end
    endtask

    task automatic check_word(string name, hilo_word_u exp, hilo_word_u act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            word_errs++;
        end
    endtask

    task automatic check_pair(string name, hilo_pair_t exp, hilo_pair_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            pair_errs++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
            bit_errs++;
        end
    endtask

    task automatic drive_bubble;
        alu_control = alu_and;  // no hilo write, releases the divider
        src_a       = '0;
        src_b       = '0;
        sa          = '0;
    endtask

    // entered and left 5 ns after a rising edge
    task automatic run_entry(entry_t e);
        alu_control = e.op;
        src_a       = e.a;
        src_b       = e.b;
        sa          = e.sa;
        #1;
        if (e.flush) begin
            check_bit("div_stall", 1'b1, div_stall);
            repeat (4) @(posedge clk);
            #5;
            flush = 1'b1;
            @(posedge clk);
            #1;
            check_bit("div_stall", 1'b0, div_stall);
            #4;
            flush = 1'b0;
            drive_bubble();
        end else begin
            while (div_stall) begin
                @(posedge clk);
                #1;
            end
            check_word("alu_out", e.exp_out, alu_out);
            check_bit("overflow", e.exp_ovf, overflow);
        end
        @(posedge clk);
        #1;
        check_pair("hilo", e.exp_hilo, hilo);
        #4;
        drive_bubble();
        @(posedge clk);
        #5;
    endtask

    initial begin
        rst         = 1'b1;
        flush       = 1'b0;
        src_a       = '0;
        src_b       = '0;
        alu_control = alu_and;
        sa          = '0;
        seed        = 32'hdf40f28a;
        model_hilo  = '0;
        word_errs   = 0;
        pair_errs   = 0;
        bit_errs    = 0;
        fill_table();
        table_ready = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #5;
        rst = 1'b0;
        #1;
        check_pair("hilo", '0, hilo);
        check_bit("div_stall", 1'b0, div_stall);
        @(posedge clk);
        #5;
        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end
        $display("errors: alu_out %0d, hilo %0d, flags %0d", word_errs, pair_errs, bit_errs);
        if (word_errs + pair_errs + bit_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // worst case entry is a full divide plus write and bubble cycles
    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(rst_cycles + table_q.size() * (div_cycles + 4)) * clk_period;
        #(limit_ns);
        $display("timeout: stimulus table not finished after %0d ns", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;     // 100 ns period
        end
    end

endmodule

//--- source/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  alu_pkg::word_t      src_a,
    input  alu_pkg::word_t      src_b,
    input  alu_pkg::alu_op_e    alu_control,
    input  alu_pkg::shamt_t     sa,
    output alu_pkg::hilo_word_u alu_out,
    output logic                overflow,
    output logic                div_stall,
    output alu_pkg::hilo_pair_t hilo
);
    import alu_pkg::*;

    logic hilo_we;

    alu i_alu (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_control (alu_control),
        .sa          (sa),
        .hilo        (hilo),
        .alu_out     (alu_out),
        .overflow    (overflow),
        .div_stall   (div_stall)
    );

    // mthi/mtlo already merged by the alu, so the whole word is written
    always_comb begin
        case (alu_control)
            alu_mult, alu_multu, alu_mthi, alu_mtlo: hilo_we = 1'b1;
            alu_div, alu_divu: hilo_we = !div_stall;   // only once quotient is ready
            default: hilo_we = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hilo <= '0;
        end else if (hilo_we) begin
            hilo <= alu_out.hl;
        end
    end

    // a stalled divide never disturbs HI/LO
    assert property (@(posedge clk) disable iff (rst)
        div_stall |=> $stable(hilo))
        else $error("exec_stage: hilo written during divide stall");

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  alu_pkg::word_t      src_a,
    input  alu_pkg::word_t      src_b,
    input  alu_pkg::alu_op_e    alu_control,
    input  alu_pkg::shamt_t     sa,
    input  alu_pkg::hilo_pair_t hilo,
    output alu_pkg::hilo_word_u alu_out,
    output logic                overflow,
    output logic                div_stall
);
    import alu_pkg::*;

    word_t      simple_res;
    logic       carry;              // 33rd sum bit for add/sub
    logic       mul_sign;
    logic       div_op;
    logic       div_sign;
    hilo_pair_t product;
    div_pair_t  quot_rem;

    always_comb begin
        carry      = 1'b0;
        simple_res = '0;
        case (alu_control)
            alu_and: simple_res = src_a & src_b;
            alu_or:  simple_res = src_a | src_b;
            alu_nor: simple_res = ~(src_a | src_b);
            alu_xor: simple_res = src_a ^ src_b;

            alu_add: begin
                {carry, simple_res} = {src_a[word_w-1], src_a} + {src_b[word_w-1], src_b};
            end
            alu_addu: simple_res = src_a + src_b;
            alu_sub: begin
                {carry, simple_res} = {src_a[word_w-1], src_a} - {src_b[word_w-1], src_b};
            end
            alu_subu: simple_res = src_a - src_b;

            alu_slt: begin
                simple_res = {{(word_w-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            end
            alu_sltu: begin
                simple_res = {{(word_w-1){1'b0}}, src_a < src_b};
            end

            alu_sll: simple_res = src_b << src_a[shamt_w-1:0];
            alu_srl: simple_res = src_b >> src_a[shamt_w-1:0];
            alu_sra: simple_res = $signed(src_b) >>> src_a[shamt_w-1:0];

            alu_sll_sa: simple_res = src_b << sa;
            alu_srl_sa: simple_res = src_b >> sa;
            alu_sra_sa: simple_res = $signed(src_b) >>> sa;

            alu_lui:  simple_res = {src_b[15:0], 16'b0};
            alu_pass: simple_res = src_a;

            default: simple_res = '0;
        endcase
    end

    // signed overflow when the two top sum bits disagree
    assign overflow = (alu_control == alu_add || alu_control == alu_sub)
                    && (carry ^ simple_res[word_w-1]);

    assign mul_sign = (alu_control == alu_mult);

    mul_booth2 i_mul (
        .a      (src_a),
        .b      (src_b),
        .sign   (mul_sign),
        .result (product)
    );

    assign div_op   = (alu_control == alu_div) || (alu_control == alu_divu);
    assign div_sign = (alu_control == alu_div);

    div_radix2 i_div (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .a      (src_a),
        .b      (src_b),
        .start  (div_op),
        .sign   (div_sign),
        .busy   (div_stall),
        .result (quot_rem)
    );

    // result select
    always_comb begin
        case (alu_control)
            alu_mult, alu_multu: alu_out.hl = product;
            alu_div, alu_divu:   alu_out.qr = quot_rem;
            alu_mthi:            alu_out.hl = {src_a, hilo.lo};   // keep lo
            alu_mtlo:            alu_out.hl = {hilo.hi, src_a};   // keep hi
            default:             alu_out.hl = {{word_w{1'b0}}, simple_res};
        endcase
    end

    // like-signed add or unlike-signed sub whose result flips sign
    assert property (@(posedge clk) disable iff (rst)
        overflow |-> ((alu_control == alu_add
                       && src_a[word_w-1] == src_b[word_w-1]
                       && simple_res[word_w-1] != src_a[word_w-1])
                   || (alu_control == alu_sub
                       && src_a[word_w-1] != src_b[word_w-1]
                       && simple_res[word_w-1] != src_a[word_w-1])))
        else $error("alu: overflow raised for code %0d", alu_control);

endmodule

//--- source/div_radix2.sv
`timescale 1ns/1ps

module div_radix2 (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  alu_pkg::word_t     a,       // dividend
    input  alu_pkg::word_t     b,       // divisor
    input  logic               start,   // level, high while div op is present
    input  logic               sign,    // 1: signed divide
    output logic               busy,
    output alu_pkg::div_pair_t result
);
    import alu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } div_state_e;

    div_state_e          state;
    div_state_e          state_next;
    logic [div_cnt_w-1:0] cnt;
    logic                flushed;       // killed op still on start
    logic                load;
    word_t               a_mag;
    word_t               b_mag;
    word_t               rem_q;
    word_t               quot_q;
    word_t               dvsr_q;
    logic                neg_quot;
    logic                neg_rem;
    logic [word_w:0]     shifted;
    logic [word_w+1:0]   diff;

    assign a_mag = (sign && a[word_w-1]) ? -a : a;
    assign b_mag = (sign && b[word_w-1]) ? -b : b;

    assign load = (state == st_idle) && start && !flushed;
    assign busy = load || (state == st_run);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: if (load) state_next = st_run;
            st_run:  if (cnt == div_cnt_w'(div_cycles - 2)) state_next = st_done;
            st_done: if (!start) state_next = st_idle;  // hold until op leaves
            default: state_next = st_idle;
        endcase
        if (flush) begin
            state_next = st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            cnt     <= '0;
            flushed <= 1'b0;
        end else begin
            state <= state_next;
            if (load) begin
                cnt <= '0;
            end else if (state == st_run) begin
                cnt <= cnt + 1'b1;
            end
            if (flush && start) begin
                flushed <= 1'b1;
            end else if (!start) begin
                flushed <= 1'b0;
            end
        end
    end

    // one restoring step: shift in next dividend bit, try subtract
    assign shifted = {rem_q, quot_q[word_w-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvsr_q};

    always_ff @(posedge clk) begin
        if (load) begin
            rem_q    <= '0;
            quot_q   <= a_mag;
            dvsr_q   <= b_mag;
            neg_quot <= sign & (a[word_w-1] ^ b[word_w-1]);
            neg_rem  <= sign & a[word_w-1];
        end else if (state == st_run) begin
            if (!diff[word_w+1]) begin
                rem_q  <= diff[word_w-1:0];
                quot_q <= {quot_q[word_w-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[word_w-1:0];
                quot_q <= {quot_q[word_w-2:0], 1'b0};
            end
        end
    end

    // truncate toward zero, remainder follows the dividend
    always_comb begin
        result.quot = neg_quot ? -quot_q : quot_q;
        result.rem  = neg_rem  ? -rem_q  : rem_q;
    end

    assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> ##[1:div_cycles] !busy)
        else $error("div_radix2: busy held longer than div_cycles");

    assert property (@(posedge clk) disable iff (rst)
        flush |=> !busy)
        else $error("div_radix2: busy still high after flush");

endmodule

//--- source/mul_booth2.sv
`timescale 1ns/1ps

module mul_booth2 (
    input  alu_pkg::word_t      a,
    input  alu_pkg::word_t      b,
    input  logic                sign,   // 1: signed operands
    output alu_pkg::hilo_pair_t result
);
    import alu_pkg::*;

    logic [mul_ext_w-1:0] a_ext;
    logic [mul_ext_w-1:0] b_ext;
    logic [mul_ext_w:0]   b_win;        // b with implicit zero below the lsb
    logic [2*word_w-1:0]  a_wide;
    logic [2*word_w-1:0]  pp [booth_groups];
    logic [2*word_w-1:0]  sum;

    // two extra bits make unsigned operands positive in two's complement
    assign a_ext = {{2{sign & a[word_w-1]}}, a};
    assign b_ext = {{2{sign & b[word_w-1]}}, b};
    assign b_win = {b_ext, 1'b0};

    assign a_wide = {{(2*word_w-mul_ext_w){a_ext[mul_ext_w-1]}}, a_ext};

    // booth recoding, each group picks 0, +-a or +-2a at weight 4^i
    always_comb begin
        for (int i = 0; i < booth_groups; i++) begin
            case (b_win[2*i +: 3])
                3'b001, 3'b010: begin
                    pp[i] = a_wide << (2*i);
                end
                3'b011: begin
                    pp[i] = a_wide << (2*i + 1);
                end
                3'b100: begin
                    pp[i] = -(a_wide << (2*i + 1));
                end
                3'b101, 3'b110: begin
                    pp[i] = -(a_wide << (2*i));
                end
                default: begin
                    pp[i] = '0;     // 000 and 111
                end
            endcase
        end
    end

    // low 64 bits of the widened product are exact for both modes
    always_comb begin
        sum = '0;
        for (int i = 0; i < booth_groups; i++) begin
            sum = sum + pp[i];
        end
    end

    assign result = sum;

    always_comb begin
        if (!$isunknown({a, b, sign})) begin
            assert final (!$isunknown(result))
                else $error("mul_booth2: unknown product from known operands");
        end
    end

endmodule

//--- source/alu_pkg.sv
package alu_pkg;

    // datapath widths
    localparam int word_w  = 32;
    localparam int shamt_w = 5;
    localparam int op_w    = 5;

    // booth multiplier: operands widened by two bits, one group per bit pair
    localparam int mul_ext_w    = word_w + 2;
    localparam int booth_groups = mul_ext_w / 2;

    // divider timing
    localparam int div_cycles = 33;     // 1 load + 32 iterations
    localparam int div_cnt_w  = 6;

    typedef logic [word_w-1:0]  word_t;
    typedef logic [shamt_w-1:0] shamt_t;

    typedef enum logic [op_w-1:0] {
        alu_and    = 5'd0,
        alu_or     = 5'd1,
        alu_nor    = 5'd2,
        alu_xor    = 5'd3,
        alu_add    = 5'd4,
        alu_addu   = 5'd5,
        alu_sub    = 5'd6,
        alu_subu   = 5'd7,
        alu_slt    = 5'd8,
        alu_sltu   = 5'd9,
        alu_sll    = 5'd10,     // shift by src_a[4:0]
        alu_srl    = 5'd11,
        alu_sra    = 5'd12,
        alu_sll_sa = 5'd13,     // shift by sa field
        alu_srl_sa = 5'd14,
        alu_sra_sa = 5'd15,
        alu_lui    = 5'd16,
        alu_pass   = 5'd17,
        alu_mthi   = 5'd18,
        alu_mtlo   = 5'd19,
        alu_mult   = 5'd20,
        alu_multu  = 5'd21,
        alu_div    = 5'd22,
        alu_divu   = 5'd23
    } alu_op_e;

    // HI/LO register contents, also the multiply product
    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_pair_t;

    // divider result, remainder lands in HI
    typedef struct packed {
        word_t rem;
        word_t quot;
    } div_pair_t;

    // one 64-bit result word, seen as hi/lo or as rem/quot
    typedef union packed {
        hilo_pair_t hl;
        div_pair_t  qr;
    } hilo_word_u;

endpackage
